//--- lineCarPkg.sv
`default_nettype none

package lineCarPkg;

    // sensor bits in order left, mid, right, 1 = on the line
    typedef enum logic [2:0] {
        roadLost        = 3'b000,
        roadSlightRight = 3'b001,
        roadCentre      = 3'b010,
        roadRight       = 3'b011,
        roadSlightLeft  = 3'b100,
        roadFork        = 3'b101,
        roadLeft        = 3'b110,
        roadCross       = 3'b111
    } roadPattern_e;

    typedef struct packed {
        logic left;
        logic mid;
        logic right;
    } trackBits_s;

    // navigation reads the pattern, the LEDs read single sensors
    typedef union packed {
        roadPattern_e pattern;
        trackBits_s   bits;
    } roadSense_u;

    typedef enum logic [4:0] {
        stIdle = 5'd0, stStart = 5'd1, stCount = 5'd2, stStraight = 5'd3,
        stChoose = 5'd4, stLeft = 5'd5, stRight = 5'd6, stBack = 5'd7,
        stLittleLeft = 5'd8, stLittleRight = 5'd9, stStop = 5'd30, stError = 5'd31
    } navState_e;

    typedef struct packed {
        logic forward;
        logic backward;
        logic pwm;
    } wheel_s;

    typedef struct packed {
        wheel_s leftWheel;
        wheel_s rightWheel;
    } motorCmd_s;

    typedef enum logic [3:0] {
        glyph0, glyph1, glyph2, glyph3, glyph4, glyph5, glyph6, glyph7, glyph8, glyph9,
        glyphCheck, glyphDash, glyphI, glyphD, glyphL, glyphR
    } glyph_e;

    // active-low segments g..a, indexed by glyph_e
    localparam logic [6:0] segmentTable [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h23, 7'h3f, 7'h4f, 7'h21, 7'h47, 7'h2f
    };

    // left LED field, one code per state
    localparam logic [4:0] lampIdle     = 5'b00000;
    localparam logic [4:0] lampStart    = 5'b00001;
    localparam logic [4:0] lampCount    = 5'b00010;
    localparam logic [4:0] lampStraight = 5'b01000;
    localparam logic [4:0] lampLeft     = 5'b10000;
    localparam logic [4:0] lampRight    = 5'b00100;
    localparam logic [4:0] lampStop     = 5'b11100;
    localparam logic [4:0] lampBack     = 5'b01010;
    localparam logic [4:0] lampError    = 5'b11111;

    // middle LED field
    localparam logic [5:0] barAll      = 6'b111111;
    localparam logic [5:0] barStraight = 6'b001100;
    localparam logic [5:0] barLeft     = 6'b110000;
    localparam logic [5:0] barRight    = 6'b000011;

    // timer lengths in clock cycles, short for simulation
    localparam int unsigned countUnitCycles = 64;
    localparam int unsigned stopPauseCycles = 128;
    localparam int unsigned backFlashCycles = 32;
    localparam int unsigned lampStepCycles  = 32;
    localparam int unsigned scanCycles      = 4;
    localparam int unsigned pwmPeriod       = 16;
    localparam int unsigned pwmFull         = 16;
    localparam int unsigned pwmSlow         = 8;
    localparam int unsigned rightLapsNeeded = 3;

endpackage

`default_nettype wire

//--- trackSampler.sv
`default_nettype none

module trackSampler import lineCarPkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        leftTrack,
    input  wire        midTrack,
    input  wire        rightTrack,
    output roadSense_u road
);

    trackBits_s syncA;
    trackBits_s syncB;
    trackBits_s lastSample;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            syncA      <= '0;
            syncB      <= '0;
            lastSample <= '0;
            road       <= '0;
        end else begin
            syncA      <= '{left: leftTrack, mid: midTrack, right: rightTrack};
            syncB      <= syncA;
            lastSample <= syncB;
            // two equal samples in a row, so a one-cycle glitch never lands
            if (syncB == lastSample) begin
                road.bits <= syncB;
            end
        end
    end

endmodule

`default_nettype wire

//--- phaseTimers.sv
`default_nettype none

module phaseTimers import lineCarPkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  navState_e state,
    output logic [1:0] countStep,
    output logic      countDone,
    output logic      flash,
    output logic      backFlash,
    output logic      resume
);

    logic [$clog2(4 * countUnitCycles + 1) - 1:0] countCnt;
    logic [$clog2(stopPauseCycles + 1) - 1:0]     stopCnt;
    logic [$clog2(backFlashCycles) - 1:0]         backCnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            countCnt  <= '0;
            stopCnt   <= '0;
            backCnt   <= '0;
            backFlash <= 1'b0;
        end else begin
            // countdown, holds at its end value until the state moves on
            if (state != stCount) countCnt <= '0;
            else if (!countDone) countCnt <= countCnt + 1'b1;

            if (state != stStop) stopCnt <= '0;
            else if (!resume) stopCnt <= stopCnt + 1'b1;

            if (state != stBack) begin
                backCnt   <= '0;
                backFlash <= 1'b0;
            end else if (32'(backCnt) == backFlashCycles - 1) begin
                backCnt   <= '0;
                backFlash <= ~backFlash;
            end else begin
                backCnt <= backCnt + 1'b1;
            end
        end
    end

    // pulses end with their state, the counter clears one edge later
    assign countDone = (state == stCount) && (32'(countCnt) == 4 * countUnitCycles);
    assign resume    = (state == stStop) && (32'(stopCnt) == stopPauseCycles);
    // last step stays at 3 through the done cycle
    assign countStep = (32'(countCnt) >= 3 * countUnitCycles) ? 2'd3
                     : 2'(32'(countCnt) / countUnitCycles);
    // half-unit bit of the countdown
    assign flash     = countCnt[$clog2(countUnitCycles) - 1];

    // each pulse belongs to its own state
    assert property (@(posedge clk) disable iff (rst) !(countDone && resume));

endmodule

`default_nettype wire

//--- routeFsm.sv
`default_nettype none

module routeFsm import lineCarPkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        run,
    input  roadSense_u road,
    input  wire        countDone,
    input  wire        resume,
    output navState_e  state,
    output navState_e  nextHeading,
    output logic       junctionSeen
);

    navState_e  stateNext;
    navState_e  headingNext;
    navState_e  prevState;
    logic       pop;
    logic       popNext;
    // checkpoints: choose, straight, left on cross, right, left on fork
    logic       cpChoose;
    logic       cpStraight;
    logic       cpLeft;
    logic       cpRight;
    logic       cpLeftFork;
    logic [1:0] rightLaps;
    logic       crossPrev;
    logic       doneRight;
    logic       onCross;
    logic       inStraight;

    assign onCross    = road.pattern == roadCross;
    assign inStraight = state inside {stStraight, stLittleLeft, stLittleRight};
    assign doneRight  = 32'(rightLaps) == rightLapsNeeded;

    always_comb begin
        stateNext   = state;
        headingNext = nextHeading;
        popNext     = pop;
        case (state)
            stIdle:  if (run) stateNext = stStart;
            stStart: if (road.pattern == roadCentre) stateNext = stCount;
            stCount: if (countDone) stateNext = stStraight;
            stStraight, stLittleLeft, stLittleRight: begin
                case (road.pattern)
                    roadSlightRight: stateNext = stLittleRight;
                    roadSlightLeft:  stateNext = stLittleLeft;
                    roadLost: begin
                        stateNext   = stStop;
                        headingNext = stBack;
                    end
                    roadCross: stateNext = cpStraight ? stChoose : stStraight;
                    default:   stateNext = stStraight;
                endcase
            end
            stChoose: begin
                if (road.pattern == roadFork) begin
                    stateNext   = stStop;
                    headingNext = stLeft;
                    if (cpChoose) popNext = 1'b1;
                end else if (onCross && cpChoose) begin
                    stateNext = stStraight;
                    popNext   = 1'b0;
                end
            end
            stLeft: begin
                if (onCross && cpLeft) begin
                    stateNext   = stStop;
                    headingNext = stStraight;
                end else if (road.pattern == roadFork && cpLeftFork) begin
                    stateNext   = stStop;
                    headingNext = stRight;
                end
            end
            stRight: begin
                if (onCross && cpRight && doneRight) begin
                    stateNext   = stStop;
                    headingNext = stStraight;
                end else if (road.pattern == roadFork && doneRight) begin
                    stateNext = stError;
                end
            end
            stBack: begin
                // dead-end exits alternate between left and right
                if (onCross) begin
                    stateNext   = stStop;
                    headingNext = pop ? stRight : stLeft;
                    popNext     = ~pop;
                end
            end
            stStop:  if (resume) stateNext = nextHeading;
            stError: stateNext = stError;
            default: stateNext = stIdle;
        endcase
        if (!run) stateNext = stIdle;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= stIdle;
            prevState   <= stIdle;
            nextHeading <= stIdle;
            pop         <= 1'b0;
        end else begin
            state       <= stateNext;
            prevState   <= state;
            nextHeading <= headingNext;
            pop         <= popNext;
        end
    end

    // a checkpoint arms once the junction pattern has been left behind
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpChoose   <= 1'b0;
            cpStraight <= 1'b0;
            cpLeft     <= 1'b0;
            cpRight    <= 1'b0;
            cpLeftFork <= 1'b0;
            rightLaps  <= '0;
            crossPrev  <= 1'b0;
        end else begin
            cpChoose   <= (state == stChoose) && (cpChoose || !onCross);
            cpLeft     <= (state == stLeft) && (cpLeft || !onCross);
            cpRight    <= (state == stRight) && (cpRight || !onCross);
            cpLeftFork <= (state == stLeft) && (cpLeftFork || road.pattern != roadFork);
            if (prevState == stCount || (inStraight && !onCross)) cpStraight <= 1'b1;
            else if (!inStraight) cpStraight <= 1'b0;

            // count fresh cross sightings during a right turn
            crossPrev <= onCross;
            if (state != stRight) rightLaps <= '0;
            else if (cpRight && onCross && !crossPrev && !doneRight) rightLaps <= rightLaps + 1'b1;
        end
    end

    always_comb begin
        case (state)
            stStraight, stLittleLeft, stLittleRight: junctionSeen = cpStraight;
            stChoose: junctionSeen = cpChoose;
            stLeft:   junctionSeen = cpLeft;
            stRight:  junctionSeen = cpRight;
            default:  junctionSeen = 1'b0;
        endcase
    end

    assert property (@(posedge clk) disable iff (rst)
        state inside {stIdle, stStart, stCount, stStraight, stChoose, stLeft, stRight,
                      stBack, stLittleLeft, stLittleRight, stStop, stError});

endmodule

`default_nettype wire

//--- statusLeds.sv
`default_nettype none

module statusLeds import lineCarPkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  navState_e   state,
    input  roadSense_u  road,
    input  wire         flash,
    input  wire         backFlash,
    output logic [15:0] led
);

    logic [$clog2(lampStepCycles) - 1:0] lampCnt;
    logic [2:0] lamp;
    logic [4:0] leftField;
    logic [5:0] midField;

    // rotating junction lamp while choosing
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lampCnt <= '0;
            lamp    <= 3'b001;
        end else if (state != stChoose) begin
            lampCnt <= '0;
            lamp    <= 3'b001;
        end else if (32'(lampCnt) == lampStepCycles - 1) begin
            lampCnt <= '0;
            lamp    <= {lamp[1:0], lamp[2]};
        end else begin
            lampCnt <= lampCnt + 1'b1;
        end
    end

    always_comb begin
        leftField = lampIdle;
        midField  = '0;
        case (state)
            stStart:    leftField = lampStart;
            stCount: begin
                leftField = lampCount;
                midField  = flash ? 6'd0 : barAll;
            end
            stStraight: begin
                leftField = lampStraight;
                midField  = barStraight;
            end
            stChoose:   leftField = {lamp, 2'b00};
            stLeft: begin
                leftField = lampLeft;
                midField  = barLeft;
            end
            stRight: begin
                leftField = lampRight;
                midField  = barRight;
            end
            stStop: begin
                leftField = lampStop;
                midField  = barAll;
            end
            stBack: begin
                leftField = lampBack;
                midField  = backFlash ? 6'd0 : barAll;
            end
            stError:    leftField = lampError;
            default:    leftField = lampIdle;
        endcase
    end

    // bits 10 and 3 stay dark as field separators
    assign led = {leftField, 1'b0, midField, 1'b0, road.bits};

endmodule

`default_nettype wire

//--- segmentDisplay.sv
`default_nettype none

module segmentDisplay import lineCarPkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  navState_e  state,
    input  navState_e  nextHeading,
    input  wire [1:0]  countStep,
    input  wire        resume,
    input  wire        junctionSeen,
    output logic [3:0] digit,
    output logic [6:0] display
);

    logic [$clog2(scanCycles) - 1:0] scanCnt;
    logic [1:0]       scanIdx;
    glyph_e [3:0]     glyphs;
    glyph_e           headingGlyph;
    glyph_e           seenGlyph;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scanCnt <= '0;
            scanIdx <= '0;
        end else if (32'(scanCnt) == scanCycles - 1) begin
            scanCnt <= '0;
            scanIdx <= scanIdx + 1'b1;
        end else begin
            scanCnt <= scanCnt + 1'b1;
        end
    end

    always_comb begin
        case (nextHeading)
            stIdle:     headingGlyph = glyphI;
            stStraight: headingGlyph = glyph1;
            stLeft:     headingGlyph = glyphL;
            stRight:    headingGlyph = glyphR;
            stBack:     headingGlyph = glyphDash;
            default:    headingGlyph = glyph0;
        endcase
    end

    assign seenGlyph = junctionSeen ? glyph1 : glyph0;

    // glyphs[0] sits on digit 0
    always_comb begin
        glyphs = {4{glyph0}};
        case (state)
            stIdle:  glyphs = {glyphL, glyphD, glyphI, glyph1};
            stStart: glyphs = {4{glyphDash}};
            stCount: begin
                glyphs    = {4{glyphDash}};
                glyphs[3] = glyph_e'(4'd3 - {2'b00, countStep});
            end
            stStraight, stLittleLeft, stLittleRight:
                glyphs = {seenGlyph, glyphDash, glyph2, glyphCheck};
            stChoose: glyphs = {seenGlyph, glyphDash, glyph1, glyphCheck};
            stLeft:   glyphs = {seenGlyph, glyphDash, glyph3, glyphCheck};
            stRight:  glyphs = {seenGlyph, glyphDash, glyph4, glyphCheck};
            stBack:   glyphs = {headingGlyph, glyph0, glyph0, glyphDash};
            stStop:   glyphs = {headingGlyph, glyph0, glyph0, resume ? glyph1 : glyph0};
            default:  glyphs = {4{glyph0}};
        endcase
    end

    assign digit   = ~(4'b0001 << scanIdx);
    assign display = segmentTable[glyphs[scanIdx]];

    assert property (@(posedge clk) disable iff (rst) $onehot(~digit));

endmodule

`default_nettype wire

//--- motorDrive.sv
`default_nettype none

module motorDrive import lineCarPkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  navState_e state,
    output motorCmd_s motor
);

    logic [$clog2(pwmPeriod) - 1:0] pwmCnt;
    logic      fullOn;
    logic      slowOn;
    motorCmd_s cmdNext;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) pwmCnt <= '0;
        else if (32'(pwmCnt) == pwmPeriod - 1) pwmCnt <= '0;
        else pwmCnt <= pwmCnt + 1'b1;
    end

    assign fullOn = 32'(pwmCnt) < pwmFull;
    assign slowOn = 32'(pwmCnt) < pwmSlow;

    // slowing one wheel steers the car toward that side
    always_comb begin
        cmdNext = '0;
        case (state)
            stStraight: begin
                cmdNext.leftWheel  = '{forward: 1'b1, backward: 1'b0, pwm: fullOn};
                cmdNext.rightWheel = '{forward: 1'b1, backward: 1'b0, pwm: fullOn};
            end
            stLittleLeft: begin
                cmdNext.leftWheel  = '{forward: 1'b1, backward: 1'b0, pwm: slowOn};
                cmdNext.rightWheel = '{forward: 1'b1, backward: 1'b0, pwm: fullOn};
            end
            stLittleRight: begin
                cmdNext.leftWheel  = '{forward: 1'b1, backward: 1'b0, pwm: fullOn};
                cmdNext.rightWheel = '{forward: 1'b1, backward: 1'b0, pwm: slowOn};
            end
            stLeft: begin
                cmdNext.leftWheel  = '{forward: 1'b0, backward: 1'b1, pwm: fullOn};
                cmdNext.rightWheel = '{forward: 1'b1, backward: 1'b0, pwm: fullOn};
            end
            stRight: begin
                cmdNext.leftWheel  = '{forward: 1'b1, backward: 1'b0, pwm: fullOn};
                cmdNext.rightWheel = '{forward: 1'b0, backward: 1'b1, pwm: fullOn};
            end
            stBack: begin
                cmdNext.leftWheel  = '{forward: 1'b0, backward: 1'b1, pwm: fullOn};
                cmdNext.rightWheel = '{forward: 1'b0, backward: 1'b1, pwm: fullOn};
            end
            default: cmdNext = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) motor <= '0;
        else motor <= cmdNext;
    end

    assert property (@(posedge clk) disable iff (rst)
        !(motor.leftWheel.forward && motor.leftWheel.backward) &&
        !(motor.rightWheel.forward && motor.rightWheel.backward));

endmodule

`default_nettype wire

//--- lineCar.sv
`default_nettype none

module lineCar import lineCarPkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         run,
    input  wire         leftTrack,
    input  wire         midTrack,
    input  wire         rightTrack,
    output logic        trig,
    output logic [15:0] led,
    output logic [3:0]  digit,
    output logic [6:0]  display,
    output logic        in1,
    output logic        in2,
    output logic        in3,
    output logic        in4,
    output logic        leftPwm,
    output logic        rightPwm
);

    roadSense_u road;
    navState_e  state;
    navState_e  nextHeading;
    logic       junctionSeen;
    logic [1:0] countStep;
    logic       countDone;
    logic       flash;
    logic       backFlash;
    logic       resume;
    motorCmd_s  motor;

    trackSampler sampler0 (.clk, .rst, .leftTrack, .midTrack, .rightTrack, .road);

    routeFsm route0 (.clk, .rst, .run, .road, .countDone, .resume, .state, .nextHeading,
        .junctionSeen);

    phaseTimers timers0 (.clk, .rst, .state, .countStep, .countDone, .flash, .backFlash,
        .resume);

    statusLeds leds0 (.clk, .rst, .state, .road, .flash, .backFlash, .led);

    segmentDisplay seg0 (.clk, .rst, .state, .nextHeading, .countStep, .resume,
        .junctionSeen, .digit, .display);

    motorDrive motor0 (.clk, .rst, .state, .motor);

    // no ranger fitted
    assign trig     = 1'b0;
    assign in1      = motor.leftWheel.forward;
    assign in2      = motor.leftWheel.backward;
    assign in3      = motor.rightWheel.forward;
    assign in4      = motor.rightWheel.backward;
    assign leftPwm  = motor.leftWheel.pwm;
    assign rightPwm = motor.rightWheel.pwm;

endmodule

`default_nettype wire

//--- lineCarTb.sv
`default_nettype none

module lineCarTb import lineCarPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // longest path through the tests is near 2000 cycles
    localparam int timeoutCycles = 4000;

    localparam wheel_s wheelFwd  = '{forward: 1'b1, backward: 1'b0, pwm: 1'b1};
    localparam wheel_s wheelBack = '{forward: 1'b0, backward: 1'b1, pwm: 1'b1};
    localparam motorCmd_s motorOff      = '0;
    localparam motorCmd_s motorForward  = '{leftWheel: wheelFwd, rightWheel: wheelFwd};
    localparam motorCmd_s motorLeftTurn = '{leftWheel: wheelBack, rightWheel: wheelFwd};
    localparam motorCmd_s motorReverse  = '{leftWheel: wheelBack, rightWheel: wheelBack};

    logic        clk;
    logic        rst;
    logic        run;
    logic        leftTrack;
    logic        midTrack;
    logic        rightTrack;
    logic        trig;
    logic [15:0] led;
    logic [3:0]  digit;
    logic [6:0]  display;
    logic        in1;
    logic        in2;
    logic        in3;
    logic        in4;
    logic        leftPwm;
    logic        rightPwm;

    int cycles = 0;
    int errorCount = 0;
    int checkCount = 0;
    int errorsBefore = 0;
    int seedValue;

    lineCar dut0 (.clk, .rst, .run, .leftTrack, .midTrack, .rightTrack, .trig, .led, .digit,
        .display, .in1, .in2, .in3, .in4, .leftPwm, .rightPwm);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    initial begin
        while (cycles < timeoutCycles) @(posedge clk);
        $display("Timeout after %0d cycles, the tests did not complete", timeoutCycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // led word from the three fields, bits 10 and 3 dark
    function automatic logic [15:0] ledWord(logic [4:0] lamp, logic [5:0] bar, roadPattern_e p);
        return {lamp, 1'b0, bar, 1'b0, p};
    endfunction

    function automatic motorCmd_s readMotor();
        motorCmd_s m;
        m.leftWheel  = '{forward: in1, backward: in2, pwm: leftPwm};
        m.rightWheel = '{forward: in3, backward: in4, pwm: rightPwm};
        return m;
    endfunction

    // direction lines only
    function automatic motorCmd_s stripPwm(motorCmd_s m);
        motorCmd_s s;
        s = m;
        s.leftWheel.pwm  = 1'b0;
        s.rightWheel.pwm = 1'b0;
        return s;
    endfunction

    task automatic checkLed(string name, logic [15:0] expected, logic [15:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic checkMotor(string name, motorCmd_s expected, motorCmd_s actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic checkLevel(string name, logic expected, logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic checkDuty(string name, int expected, int actual);
        checkCount++;
        if (actual != expected) begin
            errorCount++;
            $display("Fail at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    // waits for the digit to be scanned, then decodes its segments
    task automatic checkGlyph(int pos, glyph_e expected);
        logic [3:0] select;
        glyph_e     actual;
        bit         found;
        int         waited;
        int         i;
        select = ~(4'b0001 << pos);
        waited = 0;
        @(negedge clk);
        while (digit !== select && waited < 4 * scanCycles) begin
            @(negedge clk);
            waited++;
        end
        checkCount++;
        if (digit !== select) begin
            errorCount++;
            $display("Error at %0d ns: digit %0d was never scanned", $time, pos);
        end else begin
            found  = 1'b0;
            actual = glyph0;
            for (i = 0; i < 16; i++) begin
                if (!found && segmentTable[i] == display) begin
                    actual = glyph_e'(i);
                    found  = 1'b1;
                end
            end
            if (!found) begin
                errorCount++;
                $display("Error at %0d ns: segments %b on digit %0d match no glyph",
                    $time, display, pos);
            end else if (actual != expected) begin
                errorCount++;
                $display("Fail at %0d ns: digit %0d expected %s, got %s",
                    $time, pos, expected.name(), actual.name());
            end
        end
    endtask

    task automatic waitLamp(logic [4:0] lamp, int limit, string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (led[15:11] !== lamp && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        checkCount++;
        if (led[15:11] !== lamp) begin
            errorCount++;
            $display("Error at %0d ns: %s lamp did not light within %0d cycles",
                $time, what, limit);
        end
    endtask

    task automatic measureDuty(output int leftHigh, output int rightHigh);
        leftHigh  = 0;
        rightHigh = 0;
        repeat (pwmPeriod) begin
            @(negedge clk);
            leftHigh  += int'(leftPwm);
            rightHigh += int'(rightPwm);
        end
    endtask

    task automatic driveInputs(logic runValue, roadPattern_e p);
        roadSense_u sense;
        sense.pattern = p;
        @(posedge clk);
        #2;
        run        = runValue;
        leftTrack  = sense.bits.left;
        midTrack   = sense.bits.mid;
        rightTrack = sense.bits.right;
    endtask

    task automatic drivePattern(roadPattern_e p);
        driveInputs(1'b1, p);
    endtask

    task automatic finishTest(string name);
        $display("%s finished with %0d errors", name, errorCount - errorsBefore);
        errorsBefore = errorCount;
    endtask

    task automatic idleOutputs();
        checkLed("led", 16'h0000, led);
        checkMotor("motor", motorOff, readMotor());
        checkLevel("trig", 1'b0, trig);
        checkGlyph(0, glyph1);
        checkGlyph(1, glyphI);
        checkGlyph(2, glyphD);
        checkGlyph(3, glyphL);
    endtask

    task automatic resetAndIdle();
        @(negedge clk);
        idleOutputs();
        finishTest("reset and idle");
    endtask

    task automatic startAndCountdown();
        int startCycle;
        int k;
        driveInputs(1'b1, roadCentre);
        waitLamp(lampStart, 10, "start");
        waitLamp(lampCount, 20, "count");
        startCycle = cycles;
        // sample digit 3 well inside each countdown step
        for (k = 0; k < 4; k++) begin
            while (cycles < startCycle + k * int'(countUnitCycles) + 24) @(negedge clk);
            checkGlyph(3, glyph_e'(4'(3 - k)));
        end
        waitLamp(lampStraight, startCycle + 4 * int'(countUnitCycles) + 10 - cycles, "straight");
        repeat (2) @(negedge clk);
        checkLed("led", ledWord(lampStraight, barStraight, roadCentre), led);
        checkMotor("motor", motorForward, readMotor());
        finishTest("start and countdown");
    endtask

    task automatic steerAndMeasure(roadPattern_e p, int leftDuty, int rightDuty);
        int leftHigh;
        int rightHigh;
        drivePattern(p);
        repeat (8) @(negedge clk);
        checkLed("led[2:0]", 16'(p), 16'(led[2:0]));
        checkMotor("motor directions", stripPwm(motorForward), stripPwm(readMotor()));
        measureDuty(leftHigh, rightHigh);
        checkDuty("leftPwm high cycles", leftDuty, leftHigh);
        checkDuty("rightPwm high cycles", rightDuty, rightHigh);
    endtask

    task automatic lineCorrections();
        steerAndMeasure(roadSlightRight, pwmFull, pwmSlow);
        steerAndMeasure(roadSlightLeft, pwmSlow, pwmFull);
        steerAndMeasure(roadCentre, pwmFull, pwmFull);
        // one-cycle dropout must not reach the navigation
        repeat ($urandom % 8) @(posedge clk);
        drivePattern(roadLost);
        drivePattern(roadCentre);
        repeat (8) @(negedge clk);
        checkLed("led", ledWord(lampStraight, barStraight, roadCentre), led);
        checkMotor("motor", motorForward, readMotor());
        finishTest("line corrections");
    endtask

    task automatic junctionStop();
        int stopCycle;
        drivePattern(roadCross);
        waitLamp(5'b00100, 10, "first junction");
        checkLed("led", ledWord(5'b00100, 6'b000000, roadCross), led);
        waitLamp(5'b01000, lampStepCycles + 2, "second junction");
        waitLamp(5'b10000, lampStepCycles + 2, "third junction");
        drivePattern(roadFork);
        waitLamp(lampStop, 10, "stop");
        stopCycle = cycles;
        checkLed("led", ledWord(lampStop, barAll, roadFork), led);
        checkGlyph(3, glyphL);
        waitLamp(lampLeft, stopPauseCycles + 10, "left");
        checkCount++;
        if (cycles - stopCycle < int'(stopPauseCycles)) begin
            errorCount++;
            $display("Error at %0d ns: left turn began before the stop pause ended", $time);
        end
        repeat (2) @(negedge clk);
        checkLed("led", ledWord(lampLeft, barLeft, roadFork), led);
        checkMotor("motor", motorLeftTurn, readMotor());
        finishTest("junction");
    endtask

    task automatic deadEnd();
        int onCycles;
        int offCycles;
        // leave the left turn through a cross, back to straight
        drivePattern(roadCentre);
        repeat (8) @(negedge clk);
        drivePattern(roadCross);
        waitLamp(lampStop, 10, "stop");
        waitLamp(lampStraight, stopPauseCycles + 10, "straight");
        drivePattern(roadCentre);
        repeat (8) @(negedge clk);
        checkLed("led", ledWord(lampStraight, barStraight, roadCentre), led);
        drivePattern(roadLost);
        waitLamp(lampStop, 10, "stop");
        waitLamp(lampBack, stopPauseCycles + 10, "back");
        repeat (2) @(negedge clk);
        checkMotor("motor", motorReverse, readMotor());
        onCycles  = 0;
        offCycles = 0;
        repeat (2 * backFlashCycles) begin
            @(negedge clk);
            if (led[9:4] === barAll) onCycles++;
            else if (led[9:4] === 6'b000000) offCycles++;
        end
        checkDuty("led[9:4] on cycles", backFlashCycles, onCycles);
        checkDuty("led[9:4] off cycles", backFlashCycles, offCycles);
        drivePattern(roadCross);
        waitLamp(lampStop, 10, "stop");
        checkGlyph(3, glyphL);
        waitLamp(lampLeft, stopPauseCycles + 10, "left");
        repeat (2) @(negedge clk);
        checkLed("led", ledWord(lampLeft, barLeft, roadCross), led);
        checkMotor("motor", motorLeftTurn, readMotor());
        finishTest("dead end");
    endtask

    task automatic runSwitchOff();
        driveInputs(1'b0, roadLost);
        waitLamp(lampIdle, 4, "idle");
        repeat (8) @(negedge clk);
        idleOutputs();
        finishTest("run switch");
    endtask

    initial begin
        seedValue  = $urandom(32'h0134_1619);
        rst        = 1'b1;
        run        = 1'b0;
        leftTrack  = 1'b0;
        midTrack   = 1'b0;
        rightTrack = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        resetAndIdle();
        startAndCountdown();
        lineCorrections();
        junctionStop();
        deadEnd();
        runSwitchOff();
        $display("6 tests, %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- lineCar.f
lineCarPkg.sv
trackSampler.sv
phaseTimers.sv
routeFsm.sv
statusLeds.sv
segmentDisplay.sv
motorDrive.sv
lineCar.sv
lineCarTb.sv

//--- Bender.yml
package:
  name: lineCar

sources:
  - lineCarPkg.sv
  - trackSampler.sv
  - phaseTimers.sv
  - routeFsm.sv
  - statusLeds.sv
  - segmentDisplay.sv
  - motorDrive.sv
  - lineCar.sv
  - target: simulation
    files:
      - lineCarTb.sv
